// File: files.f
src/FetchPkg.sv
src/BlockRam.sv
src/ValidTagArray.sv
src/ICacheInvalidater.sv
src/ICacheReplacer.sv
src/FetchController.sv
src/FetchTop.sv
sim/FetchTop_props.sv
sim/FetchTb.sv

// File: sim/FetchTb.sv
/*
 * Fetch stage testbench
 * Line memory with random latency, fetch log and directed tests for
 * cold fetch, refetch, stall, invalidate and set conflicts
 */
module FetchTb;

    localparam logic [31:0] MemPattern = 32'h5a3c_96e1;
    localparam int TimeoutCycles = 3000;
    // Same set index as each other, different tags
    localparam logic [31:0] ConflictA = 32'h0000_3040;
    localparam logic [31:0] ConflictB = 32'h0000_5040;

    logic clk;
    logic rst;
    logic stall;
    logic flush;
    logic [FetchPkg::AddrWidth-1:0] flushPc;
    logic invalidate;
    logic memReadReq;
    logic [FetchPkg::MemAddrWidth-1:0] memAddr;
    logic memReadDone = 1'b0;
    logic [FetchPkg::LineWidth-1:0] memReadValue = '0;
    logic fetchValid;
    logic [FetchPkg::AddrWidth-1:0] fetchPc;
    logic [31:0] fetchInsn;

    integer memSeed = 32'h13e0;
    integer stallSeed = 32'h13e0;
    int cycleCount = 0;
    int reqCount = 0;
    logic [31:0] pcLog [$];
    logic [31:0] insnLog [$];

    logic memPending = 1'b0;
    int memDelay = 0;
    logic [FetchPkg::MemAddrWidth-1:0] memLine = '0;

    FetchTop UUT (
        .clk, .rst, .stall, .flush, .flushPc, .invalidate,
        .memReadReq, .memAddr, .memReadDone, .memReadValue,
        .fetchValid, .fetchPc, .fetchInsn
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] wordAt(input logic [31:0] addr);
        return addr ^ MemPattern;
    endfunction

    function automatic logic [FetchPkg::LineWidth-1:0] lineAt(
        input logic [FetchPkg::MemAddrWidth-1:0] lineAddr
    );
        logic [FetchPkg::LineWidth-1:0] line;
        logic [31:0] base;
        int w;
        base = {lineAddr, 4'h0};
        for (w = 0; w < FetchPkg::LineSize / FetchPkg::InsnSize; w++) begin
            line[w*32 +: 32] = wordAt(base + 32'(w * FetchPkg::InsnSize));
        end
        return line;
    endfunction

    // Memory answers one line request after 1 to 8 cycles
    always @(negedge clk) begin
        memReadDone = 1'b0;
        if (rst) begin
            memPending = 1'b0;
        end else if (memPending) begin
            if (memDelay <= 1) begin
                memReadDone = 1'b1;
                memReadValue = lineAt(memLine);
                memPending = 1'b0;
            end else begin
                memDelay = memDelay - 1;
            end
        end else if (memReadReq) begin
            memPending = 1'b1;
            memLine = memAddr;
            memDelay = $unsigned($random(memSeed)) % 8 + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst && memReadReq) begin
            reqCount++;
        end
        if (!rst && fetchValid) begin
            pcLog.push_back(fetchPc);
            insnLog.push_back(fetchInsn);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
            $display("Test FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    // Port assertions of the bound checker
    always @(negedge clk) begin
        if (UUT.props.failureCount != 0) begin
            $display("Port property failed: a bound assertion on the fetch ports fired");
            $display("Test FAILED");
            $fatal(1, "stopped at first property failure");
        end
    end

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic flushTo(input logic [31:0] target);
        flush = 1'b1;
        flushPc = target;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // Runs until count instructions are delivered, then stalls to park the PC
    task automatic runFetch(input int count, input bit randomStall);
        int got;
        int stretch;
        got = 0;
        stretch = 0;
        stall = 1'b0;
        while (got < count) begin
            @(negedge clk);
            if (fetchValid) begin
                got++;
            end
            if (got == count) begin
                stall = 1'b1;
            end else if (stretch > 0) begin
                stall = 1'b1;
                stretch--;
            end else if (randomStall && $unsigned($random(stallSeed)) % 3 == 0) begin
                stall = 1'b1;
                stretch = $unsigned($random(stallSeed)) % 4;
            end else begin
                stall = 1'b0;
            end
        end
        @(negedge clk);
    endtask

    task automatic checkRun(input logic [31:0] startPc, input int count, input int firstEntry,
                            input int reqsBefore, input int expectedReqs);
        logic [31:0] pc;
        int k;
        checkEqual(pcLog.size() - firstEntry, count, "delivered instruction count");
        for (k = 0; k < count; k++) begin
            pc = startPc + 32'(k * FetchPkg::InsnSize);
            checkEqual(pcLog[firstEntry + k], pc, "fetch PC");
            checkEqual(insnLog[firstEntry + k], wordAt(pc), "fetch instruction");
        end
        checkEqual(reqCount - reqsBefore, expectedReqs, "memory request count");
    endtask

    task automatic coldFetchTest();
        int firstEntry;
        int reqsBefore;
        firstEntry = pcLog.size();
        reqsBefore = reqCount;
        runFetch(12, 1'b0);
        checkRun(FetchPkg::ResetPc, 12, firstEntry, reqsBefore, 3);
    endtask

    task automatic refetchTest(input bit randomStall);
        int firstEntry;
        int reqsBefore;
        firstEntry = pcLog.size();
        reqsBefore = reqCount;
        flushTo(FetchPkg::ResetPc);
        runFetch(12, randomStall);
        checkRun(FetchPkg::ResetPc, 12, firstEntry, reqsBefore, 0);
    endtask

    task automatic invalidateTest();
        int firstEntry;
        int reqsBefore;
        firstEntry = pcLog.size();
        reqsBefore = reqCount;
        invalidate = 1'b1;
        @(negedge clk);
        invalidate = 1'b0;
        flushTo(FetchPkg::ResetPc);
        runFetch(12, 1'b0);
        checkRun(FetchPkg::ResetPc, 12, firstEntry, reqsBefore, 3);
    endtask

    task automatic conflictTest();
        logic [31:0] target;
        int firstEntry;
        int reqsBefore;
        int s;
        for (s = 0; s < 4; s++) begin
            target = s[0] ? ConflictB : ConflictA;
            firstEntry = pcLog.size();
            reqsBefore = reqCount;
            flushTo(target);
            runFetch(4, 1'b0);
            checkRun(target, 4, firstEntry, reqsBefore, 1);
        end
    endtask

    initial begin
        rst = 1'b1;
        stall = 1'b1;
        flush = 1'b0;
        flushPc = '0;
        invalidate = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        coldFetchTest();
        refetchTest(1'b0);
        refetchTest(1'b1);
        invalidateTest();
        conflictTest();

        if (UUT.props.failureCount == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Port property failed before the end of the run");
            $display("Test FAILED");
            $fatal(1, "stopped at property failure");
        end
    end

endmodule

// File: sim/FetchTop_props.sv
/*
 * Fetch stage port properties
 * Bound to the fetch top level, checks stall response and the memory strobe
 */
module FetchTopProps (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic fetchValid,
    input logic memReadReq
);

    int failureCount = 0;

    // No delivery in the cycle after a stall
    assert property (@(posedge clk) disable iff (rst) stall |=> !fetchValid)
        else begin
            $error("fetchValid high in the cycle after stall");
            failureCount++;
        end

    assert property (@(posedge clk) disable iff (rst) memReadReq |=> !memReadReq)
        else begin
            $error("memReadReq held high for two cycles");
            failureCount++;
        end

    assert property (@(posedge clk) disable iff (rst) !(fetchValid && memReadReq))
        else begin
            $error("fetchValid and memReadReq high in the same cycle");
            failureCount++;
        end

endmodule

bind FetchTop FetchTopProps props (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .fetchValid(fetchValid),
    .memReadReq(memReadReq)
);

// File: src/BlockRam.sv
/*
 * Single-port block RAM
 * Registered read, write-first when reading the address being written
 */
module BlockRam #(
    parameter int DataWidth = 32,
    parameter int IndexWidth = 4
) (
    input  logic                  clk,
    input  logic [IndexWidth-1:0] index,
    input  logic [DataWidth-1:0]  writeValue,
    input  logic                  writeEnable,
    output logic [DataWidth-1:0]  readValue
);

    logic [DataWidth-1:0] mem [1 << IndexWidth];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[index] <= writeValue;
            readValue <= writeValue;
        end else begin
            readValue <= mem[index];
        end
    end

endmodule

// File: src/FetchController.sv
/*
 * Fetch controller
 * Owns the PC and the fetch state machine. Checks the hit one cycle
 * after addressing the arrays, selects the instruction word and hands
 * the array ports to the replacer or invalidater while they run
 */
module FetchController (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              stall,
    input  logic                              flush,
    input  logic [FetchPkg::AddrWidth-1:0]    flushPc,
    input  logic                              tagReadValid,
    input  logic [FetchPkg::TagWidth-1:0]     tagReadTag,
    input  logic [FetchPkg::LineWidth-1:0]    dataReadValue,
    input  logic                              invalidaterArrayWriteEnable,
    input  logic [FetchPkg::IndexWidth-1:0]   invalidaterArrayIndex,
    input  logic                              invalidaterDone,
    input  logic                              waitInvalidate,
    input  logic                              replacerArrayWriteEnable,
    input  logic [FetchPkg::IndexWidth-1:0]   replacerArrayIndex,
    input  logic [FetchPkg::TagWidth-1:0]     replacerArrayWriteTag,
    input  logic                              replacerDone,
    output logic                              fetchValid,
    output logic [FetchPkg::AddrWidth-1:0]    fetchPc,
    output logic [31:0]                       fetchInsn,
    output logic [FetchPkg::IndexWidth-1:0]   arrayIndex,
    output logic                              tagWriteEnable,
    output logic                              tagWriteValid,
    output logic [FetchPkg::TagWidth-1:0]     tagWriteTag,
    output logic                              dataWriteEnable,
    output logic                              invalidaterEnable,
    output logic                              replacerEnable,
    output logic [FetchPkg::MemAddrWidth-1:0] missAddr
);

    typedef logic [$clog2(FetchPkg::StallCycleAfterFlush):0] StallCount;

    FetchPkg::FetchState state;
    FetchPkg::FetchState nextState;
    logic [FetchPkg::AddrWidth-1:0] pc;
    logic [FetchPkg::AddrWidth-1:0] nextPc;
    logic readIssued;
    logic nextReadIssued;
    StallCount stallCounter;
    StallCount nextStallCounter;

    logic hit;
    logic miss;
    logic [$clog2(FetchPkg::LineSize / FetchPkg::InsnSize)-1:0] wordSel;

    always_comb begin
        hit = tagReadValid &&
            tagReadTag == pc[FetchPkg::AddrWidth-1:FetchPkg::IndexLsb+FetchPkg::IndexWidth];
        miss = readIssued && !hit;
        fetchValid = readIssued && hit && !flush;
        fetchPc = pc;
        wordSel = pc[FetchPkg::IndexLsb-1:$clog2(FetchPkg::InsnSize)];
        fetchInsn = dataReadValue[wordSel*32 +: 32];
        missAddr = pc[FetchPkg::AddrWidth-1:FetchPkg::IndexLsb];

        if (flush) begin
            nextStallCounter = StallCount'(FetchPkg::StallCycleAfterFlush);
        end else if (stallCounter != '0) begin
            nextStallCounter = stallCounter - 1'b1;
        end else begin
            nextStallCounter = '0;
        end

        unique case (state)
            FetchPkg::StateInvalidate: begin
                if (invalidaterDone && !waitInvalidate) begin
                    nextState = flush ? FetchPkg::StateFlushWait : FetchPkg::StateFetch;
                end else begin
                    nextState = FetchPkg::StateInvalidate;
                end
            end
            FetchPkg::StateRefill: begin
                if (!replacerDone) begin
                    nextState = FetchPkg::StateRefill;
                end else if (waitInvalidate) begin
                    nextState = FetchPkg::StateInvalidate;
                end else begin
                    nextState = flush ? FetchPkg::StateFlushWait : FetchPkg::StateFetch;
                end
            end
            FetchPkg::StateFlushWait: begin
                if (flush || nextStallCounter != '0) begin
                    nextState = FetchPkg::StateFlushWait;
                end else begin
                    nextState = waitInvalidate ? FetchPkg::StateInvalidate : FetchPkg::StateFetch;
                end
            end
            default: begin
                if (flush) begin
                    nextState = FetchPkg::StateFlushWait;
                end else if (waitInvalidate) begin
                    nextState = FetchPkg::StateInvalidate;
                end else if (miss) begin
                    nextState = FetchPkg::StateRefill;
                end else begin
                    nextState = FetchPkg::StateFetch;
                end
            end
        endcase

        // A delivered instruction always advances the PC, even under stall
        if (flush) begin
            nextPc = flushPc;
        end else if (!fetchValid) begin
            nextPc = pc;
        end else begin
            nextPc = pc + FetchPkg::InsnSize;
        end

        // Arrays follow the PC only while no refill or sweep owns them
        nextReadIssued = (state == FetchPkg::StateFetch || state == FetchPkg::StateFlushWait) &&
            nextState == FetchPkg::StateFetch && !stall && nextStallCounter == '0;

        arrayIndex = nextPc[FetchPkg::IndexLsb+FetchPkg::IndexWidth-1:FetchPkg::IndexLsb];
        tagWriteEnable = 1'b0;
        tagWriteValid = 1'b0;
        tagWriteTag = replacerArrayWriteTag;
        dataWriteEnable = 1'b0;
        if (state == FetchPkg::StateInvalidate) begin
            arrayIndex = invalidaterArrayIndex;
            tagWriteEnable = invalidaterArrayWriteEnable;
        end else if (state == FetchPkg::StateRefill) begin
            arrayIndex = replacerArrayIndex;
            tagWriteEnable = replacerArrayWriteEnable;
            tagWriteValid = 1'b1;
            dataWriteEnable = replacerArrayWriteEnable;
        end

        invalidaterEnable = state == FetchPkg::StateInvalidate;
        replacerEnable = state == FetchPkg::StateRefill;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FetchPkg::StateFetch;
            pc <= FetchPkg::ResetPc;
            readIssued <= 1'b0;
            stallCounter <= '0;
        end else begin
            state <= nextState;
            pc <= nextPc;
            readIssued <= nextReadIssued;
            stallCounter <= nextStallCounter;
        end
    end

endmodule

// File: src/FetchPkg.sv
/*
 * Fetch stage definitions
 * Instruction cache geometry, reset PC and the fetch controller states
 */
package FetchPkg;

    localparam int AddrWidth = 32;
    localparam int InsnSize = 4;

    // Direct-mapped cache, 16 sets of 16-byte lines
    localparam int LineSize = 16;
    localparam int LineWidth = LineSize * 8;
    localparam int IndexWidth = 4;
    localparam int IndexLsb = $clog2(LineSize);
    localparam int TagWidth = AddrWidth - IndexLsb - IndexWidth;

    // Line address as seen by the memory port
    localparam int MemAddrWidth = AddrWidth - IndexLsb;

    localparam logic [AddrWidth-1:0] ResetPc = 32'h0000_1000;

    // Dead cycles after a pipeline flush
    localparam int StallCycleAfterFlush = 2;

    typedef enum logic [1:0] {
        StateFetch = 2'h0,
        StateInvalidate = 2'h1,
        StateRefill = 2'h2,
        StateFlushWait = 2'h3
    } FetchState;

endpackage

// File: src/FetchTop.sv
/*
 * Instruction fetch stage
 * Fetch controller with its direct-mapped instruction cache arrays,
 * invalidater and line refill unit
 */
module FetchTop (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              stall,
    input  logic                              flush,
    input  logic [FetchPkg::AddrWidth-1:0]    flushPc,
    input  logic                              invalidate,
    output logic                              memReadReq,
    output logic [FetchPkg::MemAddrWidth-1:0] memAddr,
    input  logic                              memReadDone,
    input  logic [FetchPkg::LineWidth-1:0]    memReadValue,
    output logic                              fetchValid,
    output logic [FetchPkg::AddrWidth-1:0]    fetchPc,
    output logic [31:0]                       fetchInsn
);

    logic [FetchPkg::IndexWidth-1:0] arrayIndex;
    logic tagReadValid;
    logic [FetchPkg::TagWidth-1:0] tagReadTag;
    logic tagWriteEnable;
    logic tagWriteValid;
    logic [FetchPkg::TagWidth-1:0] tagWriteTag;
    logic [FetchPkg::LineWidth-1:0] dataReadValue;
    logic [FetchPkg::LineWidth-1:0] dataWriteValue;
    logic dataWriteEnable;

    logic invalidaterEnable;
    logic invalidaterArrayWriteEnable;
    logic [FetchPkg::IndexWidth-1:0] invalidaterArrayIndex;
    logic invalidaterDone;
    logic waitInvalidate;

    logic replacerEnable;
    logic replacerArrayWriteEnable;
    logic [FetchPkg::IndexWidth-1:0] replacerArrayIndex;
    logic [FetchPkg::TagWidth-1:0] replacerArrayWriteTag;
    logic replacerDone;
    logic [FetchPkg::MemAddrWidth-1:0] missAddr;

    FetchController controller (
        .clk, .rst, .stall, .flush, .flushPc,
        .tagReadValid, .tagReadTag, .dataReadValue,
        .invalidaterArrayWriteEnable, .invalidaterArrayIndex, .invalidaterDone, .waitInvalidate,
        .replacerArrayWriteEnable, .replacerArrayIndex, .replacerArrayWriteTag, .replacerDone,
        .fetchValid, .fetchPc, .fetchInsn,
        .arrayIndex, .tagWriteEnable, .tagWriteValid, .tagWriteTag, .dataWriteEnable,
        .invalidaterEnable, .replacerEnable, .missAddr
    );

    BlockRam #(
        .DataWidth(FetchPkg::LineWidth),
        .IndexWidth(FetchPkg::IndexWidth)
    ) dataArray (
        .clk,
        .index(arrayIndex),
        .writeValue(dataWriteValue),
        .writeEnable(dataWriteEnable),
        .readValue(dataReadValue)
    );

    ValidTagArray validTagArray (
        .clk, .rst,
        .index(arrayIndex),
        .writeValid(tagWriteValid),
        .writeTag(tagWriteTag),
        .writeEnable(tagWriteEnable),
        .readValid(tagReadValid),
        .readTag(tagReadTag)
    );

    ICacheInvalidater invalidater (
        .clk, .rst, .invalidate,
        .enable(invalidaterEnable),
        .arrayWriteEnable(invalidaterArrayWriteEnable),
        .arrayIndex(invalidaterArrayIndex),
        .waitInvalidate,
        .done(invalidaterDone)
    );

    ICacheReplacer replacer (
        .clk, .rst,
        .enable(replacerEnable),
        .missAddr,
        .memReadDone, .memReadValue, .memReadReq, .memAddr,
        .arrayWriteEnable(replacerArrayWriteEnable),
        .arrayIndex(replacerArrayIndex),
        .arrayWriteTag(replacerArrayWriteTag),
        .arrayWriteData(dataWriteValue),
        .done(replacerDone)
    );

endmodule

// File: src/ICacheInvalidater.sv
/*
 * Instruction cache invalidater
 * Holds an invalidate request until the controller starts a sweep,
 * then clears the valid bit of one set per cycle
 */
module ICacheInvalidater (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            invalidate,
    input  logic                            enable,
    output logic                            arrayWriteEnable,
    output logic [FetchPkg::IndexWidth-1:0] arrayIndex,
    output logic                            waitInvalidate,
    output logic                            done
);

    logic [FetchPkg::IndexWidth-1:0] setCounter;
    logic sweepStart;

    assign sweepStart = enable && setCounter == '0;

    assign arrayWriteEnable = enable;
    assign arrayIndex = setCounter;
    assign done = enable && setCounter == '1;

    always_ff @(posedge clk) begin
        if (rst) begin
            setCounter <= '0;
            waitInvalidate <= 1'b0;
        end else begin
            // Wraps back to set 0 after the last set
            if (enable) begin
                setCounter <= setCounter + 1'b1;
            end

            // A new request wins over the clear and asks for another pass
            if (invalidate) begin
                waitInvalidate <= 1'b1;
            end else if (sweepStart) begin
                waitInvalidate <= 1'b0;
            end
        end
    end

endmodule

// File: src/ICacheReplacer.sv
/*
 * Instruction cache line replacer
 * Requests the missed line from memory, waits for the answer and
 * writes line, tag and valid bit in one cycle, then pulses done
 */
module ICacheReplacer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic [FetchPkg::MemAddrWidth-1:0] missAddr,
    input  logic                              memReadDone,
    input  logic [FetchPkg::LineWidth-1:0]    memReadValue,
    output logic                              memReadReq,
    output logic [FetchPkg::MemAddrWidth-1:0] memAddr,
    output logic                              arrayWriteEnable,
    output logic [FetchPkg::IndexWidth-1:0]   arrayIndex,
    output logic [FetchPkg::TagWidth-1:0]     arrayWriteTag,
    output logic [FetchPkg::LineWidth-1:0]    arrayWriteData,
    output logic                              done
);

    logic busy;
    logic waiting;
    logic lineReady;
    logic finished;

    logic [FetchPkg::MemAddrWidth-1:0] lineAddr;
    logic [FetchPkg::LineWidth-1:0] line;

    // Request goes out in the first enabled cycle only
    assign memReadReq = enable && !busy;
    assign memAddr = missAddr;

    assign arrayWriteEnable = lineReady;
    assign arrayIndex = lineAddr[FetchPkg::IndexWidth-1:0];
    assign arrayWriteTag = lineAddr[FetchPkg::MemAddrWidth-1:FetchPkg::IndexWidth];
    assign arrayWriteData = line;
    assign done = finished;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            waiting <= 1'b0;
            lineReady <= 1'b0;
            finished <= 1'b0;
        end else begin
            if (memReadReq) begin
                busy <= 1'b1;
            end else if (finished) begin
                busy <= 1'b0;
            end

            if (memReadReq) begin
                waiting <= 1'b1;
            end else if (memReadDone) begin
                waiting <= 1'b0;
            end

            lineReady <= waiting && memReadDone;
            finished <= lineReady;
        end
    end

    // Miss address is kept since the PC may be redirected during refill
    always_ff @(posedge clk) begin
        if (memReadReq) begin
            lineAddr <= missAddr;
        end
        if (waiting && memReadDone) begin
            line <= memReadValue;
        end
    end

endmodule

// File: src/ValidTagArray.sv
/*
 * Valid and tag storage of the instruction cache
 * Tags sit in a RAM, valid bits in flops cleared on reset.
 * Registered read with write-first behavior
 */
module ValidTagArray (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [FetchPkg::IndexWidth-1:0] index,
    input  logic                           writeValid,
    input  logic [FetchPkg::TagWidth-1:0]  writeTag,
    input  logic                           writeEnable,
    output logic                           readValid,
    output logic [FetchPkg::TagWidth-1:0]  readTag
);

    logic [FetchPkg::TagWidth-1:0] tags [1 << FetchPkg::IndexWidth];
    logic [(1 << FetchPkg::IndexWidth)-1:0] valids;

    always_ff @(posedge clk) begin
        if (rst) begin
            valids <= '0;
            readValid <= 1'b0;
        end else if (writeEnable) begin
            valids[index] <= writeValid;
            readValid <= writeValid;
        end else begin
            readValid <= valids[index];
        end
    end

    // Tag contents only matter once the valid bit is set
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            tags[index] <= writeTag;
            readTag <= writeTag;
        end else begin
            readTag <= tags[index];
        end
    end

endmodule
